/* build.f */
+incdir+include
logic/mem_if_pkg.sv
logic/axi_write_ctrl.sv
logic/axi_read_ctrl.sv
logic/mem_port_arbiter.sv
logic/axi_mem_if_sp.sv
verification/sp_sram_model.sv
verification/axi_mem_if_tb.sv

/* include/mem_if_macros.svh */
// --------------------
// Bus and SRAM widths for the AXI to SRAM bridge
// Included by the package and by the testbench
// --------------------

`ifndef MEM_IF_MACROS_SVH
`define MEM_IF_MACROS_SVH

// AXI side
`define MEM_IF_ID_WIDTH        4
`define MEM_IF_ADDR_WIDTH      32
`define MEM_IF_DATA_WIDTH      32
`define MEM_IF_LEN_WIDTH       8

// Word addressed SRAM side
`define MEM_IF_MEM_ADDR_WIDTH  10

`endif

/* logic/axi_mem_if_sp.sv */
// --------------------
// AXI4 slave to single-port SRAM bridge, top level
// Write and read controllers share the SRAM through the arbiter
// --------------------

`timescale 1ns/10ps
`default_nettype none

module axi_mem_if_sp
(
    input  wire                          ACLK,
    input  wire                          ARESETn,

    input  wire mem_if_pkg::aw_chan_t    aw_i,
    input  wire                          aw_valid_i,
    output logic                         aw_ready_o,

    input  wire mem_if_pkg::w_chan_t     w_i,
    input  wire                          w_valid_i,
    output logic                         w_ready_o,

    output mem_if_pkg::b_chan_t          b_o,
    output logic                         b_valid_o,
    input  wire                          b_ready_i,

    input  wire mem_if_pkg::ar_chan_t    ar_i,
    input  wire                          ar_valid_i,
    output logic                         ar_ready_o,

    output mem_if_pkg::r_chan_t          r_o,
    output logic                         r_valid_o,
    input  wire                          r_ready_i,

    // SRAM port
    output mem_if_pkg::mem_port_t        mem_o,
    input  wire mem_if_pkg::axi_data_t   mem_q_i
);

    mem_if_pkg::mem_wr_req_t wr_req;
    logic                    wr_valid;
    logic                    wr_grant;

    mem_if_pkg::mem_addr_t   rd_addr;
    logic                    rd_valid;
    logic                    rd_grant;
    mem_if_pkg::axi_data_t   rd_q;

    // --------------------
    // Request stage
    axi_write_ctrl u_write_ctrl
    (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_i       (aw_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .w_i        (w_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_o        (b_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .wr_req_o   (wr_req),
        .wr_valid_o (wr_valid),
        .wr_grant_i (wr_grant)
    );

    axi_read_ctrl u_read_ctrl
    (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .ar_i       (ar_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .rd_addr_o  (rd_addr),
        .rd_valid_o (rd_valid),
        .rd_grant_i (rd_grant),
        .rd_q_i     (rd_q)
    );

    // --------------------
    // Arbitration stage
    mem_port_arbiter u_arbiter
    (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .wr_req_i   (wr_req),
        .wr_valid_i (wr_valid),
        .wr_grant_o (wr_grant),
        .rd_addr_i  (rd_addr),
        .rd_valid_i (rd_valid),
        .rd_grant_o (rd_grant),
        .mem_o      (mem_o),
        .mem_q_i    (mem_q_i),
        .rd_q_o     (rd_q)
    );

endmodule

`default_nettype wire

/* logic/axi_read_ctrl.sv */
// --------------------
// AXI read burst controller
// Issues one SRAM read per beat, captures the word and holds it on R
// --------------------

`timescale 1ns/10ps
`default_nettype none

module axi_read_ctrl
(
    input  wire                          ACLK,
    input  wire                          ARESETn,

    input  wire mem_if_pkg::ar_chan_t    ar_i,
    input  wire                          ar_valid_i,
    output logic                         ar_ready_o,

    output mem_if_pkg::r_chan_t          r_o,
    output logic                         r_valid_o,
    input  wire                          r_ready_i,

    // Request towards the arbiter
    output mem_if_pkg::mem_addr_t        rd_addr_o,
    output logic                         rd_valid_o,
    input  wire                          rd_grant_i,
    input  wire mem_if_pkg::axi_data_t   rd_q_i
);

    mem_if_pkg::rd_state_t state_q;
    mem_if_pkg::rd_state_t state_d;

    mem_if_pkg::axi_id_t   id_q;
    mem_if_pkg::mem_addr_t addr_q;
    // Beats still to go after the current one
    mem_if_pkg::axi_len_t  cnt_q;

    logic ar_hs;
    logic r_hs;
    logic last_beat;

    assign ar_hs     = ar_valid_i & ar_ready_o;
    assign r_hs      = r_valid_o & r_ready_i;
    assign last_beat = (cnt_q == '0);

    // --------------------
    // Handshake outputs
    assign ar_ready_o = (state_q == mem_if_pkg::RD_IDLE);
    assign rd_valid_o = (state_q == mem_if_pkg::RD_REQ);
    assign r_valid_o  = (state_q == mem_if_pkg::RD_RESP);
    assign rd_addr_o  = addr_q;

    // --------------------
    // FSM
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            mem_if_pkg::RD_IDLE:
                if (ar_valid_i)
                    state_d = mem_if_pkg::RD_REQ;
            mem_if_pkg::RD_REQ:
                if (rd_grant_i)
                    state_d = mem_if_pkg::RD_WAIT;
            // SRAM data shows up during this cycle
            mem_if_pkg::RD_WAIT:
                state_d = mem_if_pkg::RD_RESP;
            mem_if_pkg::RD_RESP:
            begin
                if (r_ready_i)
                begin
                    if (last_beat)
                        state_d = mem_if_pkg::RD_IDLE;
                    else
                        state_d = mem_if_pkg::RD_REQ;
                end
            end
            default:
                state_d = mem_if_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= mem_if_pkg::RD_IDLE;
        else
            state_q <= state_d;
    end

    // Burst address and count
    always_ff @(posedge ACLK)
    begin
        if (ar_hs)
        begin
            id_q   <= ar_i.id;
            addr_q <= mem_if_pkg::mem_addr_t'(ar_i.addr >> 2);
            cnt_q  <= ar_i.len;
        end
        else if (r_hs && !last_beat)
        begin
            addr_q <= addr_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
        end
    end

    // --------------------
    // Response stage holds the R payload until the handshake
    always_ff @(posedge ACLK)
    begin
        if (state_q == mem_if_pkg::RD_WAIT)
        begin
            r_o.id   <= id_q;
            r_o.data <= rd_q_i;
            r_o.resp <= mem_if_pkg::RESP_OKAY;
            r_o.last <= last_beat;
        end
    end

endmodule

`default_nettype wire

/* logic/axi_write_ctrl.sv */
// --------------------
// AXI write burst controller
// Turns AW and W beats into SRAM write requests and answers on B
// --------------------

`timescale 1ns/10ps
`default_nettype none

module axi_write_ctrl
(
    input  wire                          ACLK,
    input  wire                          ARESETn,

    input  wire mem_if_pkg::aw_chan_t    aw_i,
    input  wire                          aw_valid_i,
    output logic                         aw_ready_o,

    input  wire mem_if_pkg::w_chan_t     w_i,
    input  wire                          w_valid_i,
    output logic                         w_ready_o,

    output mem_if_pkg::b_chan_t          b_o,
    output logic                         b_valid_o,
    input  wire                          b_ready_i,

    // Request towards the arbiter
    output mem_if_pkg::mem_wr_req_t      wr_req_o,
    output logic                         wr_valid_o,
    input  wire                          wr_grant_i
);

    mem_if_pkg::wr_state_t state_q;
    mem_if_pkg::wr_state_t state_d;

    // Burst bookkeeping
    mem_if_pkg::axi_id_t   id_q;
    mem_if_pkg::mem_addr_t addr_q;
    mem_if_pkg::axi_len_t  cnt_q;

    logic aw_hs;
    logic w_hs;
    logic burst_end;

    assign aw_hs     = aw_valid_i & aw_ready_o;
    assign w_hs      = w_valid_i & w_ready_o;
    // Burst ends on WLAST or on the len+1th beat
    assign burst_end = w_i.last | (cnt_q == '0);

    // --------------------
    // Handshake outputs
    assign aw_ready_o = (state_q == mem_if_pkg::WR_IDLE);
    assign b_valid_o  = (state_q == mem_if_pkg::WR_RESP);
    assign wr_valid_o = (state_q == mem_if_pkg::WR_DATA) & w_valid_i;
    // A beat is taken on the edge where the SRAM write happens
    assign w_ready_o  = wr_grant_i;

    always_comb
    begin
        wr_req_o.addr = addr_q;
        wr_req_o.data = w_i.data;
        wr_req_o.be   = w_i.strb;
    end

    always_comb
    begin
        b_o.id   = id_q;
        b_o.resp = mem_if_pkg::RESP_OKAY;
    end

    // --------------------
    // FSM
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            mem_if_pkg::WR_IDLE:
                if (aw_valid_i)
                    state_d = mem_if_pkg::WR_DATA;
            mem_if_pkg::WR_DATA:
                if (w_hs && burst_end)
                    state_d = mem_if_pkg::WR_RESP;
            mem_if_pkg::WR_RESP:
                if (b_ready_i)
                    state_d = mem_if_pkg::WR_IDLE;
            default:
                state_d = mem_if_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            state_q <= mem_if_pkg::WR_IDLE;
        else
            state_q <= state_d;
    end

    // Address and count advance once per accepted beat
    always_ff @(posedge ACLK)
    begin
        if (aw_hs)
        begin
            id_q   <= aw_i.id;
            addr_q <= mem_if_pkg::mem_addr_t'(aw_i.addr >> 2);
            cnt_q  <= aw_i.len;
        end
        else if (w_hs)
        begin
            addr_q <= addr_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/mem_if_pkg.sv */
// --------------------
// Shared types of the AXI to SRAM bridge
// Channel structs, SRAM port struct and FSM encodings
// --------------------

`default_nettype none

`include "mem_if_macros.svh"

package mem_if_pkg;

    // --------------------
    // Plain vectors
    typedef logic [`MEM_IF_ID_WIDTH-1:0]       axi_id_t;
    typedef logic [`MEM_IF_ADDR_WIDTH-1:0]     axi_addr_t;
    typedef logic [`MEM_IF_DATA_WIDTH-1:0]     axi_data_t;
    typedef logic [`MEM_IF_LEN_WIDTH-1:0]      axi_len_t;
    typedef logic [`MEM_IF_DATA_WIDTH/8-1:0]   axi_strb_t;
    typedef logic [1:0]                        axi_resp_t;
    typedef logic [`MEM_IF_MEM_ADDR_WIDTH-1:0] mem_addr_t;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    // --------------------
    // AXI channels
    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } aw_chan_t;

    typedef struct packed {
        axi_id_t   id;
        axi_addr_t addr;
        axi_len_t  len;
    } ar_chan_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } w_chan_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } b_chan_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } r_chan_t;

    // --------------------
    // SRAM side
    typedef struct packed {
        mem_addr_t addr;
        axi_data_t data;
        axi_strb_t be;
    } mem_wr_req_t;

    // cen and wen are active low
    typedef struct packed {
        logic      cen;
        logic      wen;
        mem_addr_t addr;
        axi_data_t data;
        axi_strb_t be;
    } mem_port_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_RESP} rd_state_t;

endpackage

`default_nettype wire

/* logic/mem_port_arbiter.sv */
// --------------------
// Round-robin sharing of the single SRAM port
// Priority swaps after every access
// --------------------

`timescale 1ns/10ps
`default_nettype none

module mem_port_arbiter
(
    input  wire                          ACLK,
    input  wire                          ARESETn,

    input  wire mem_if_pkg::mem_wr_req_t wr_req_i,
    input  wire                          wr_valid_i,
    output logic                         wr_grant_o,

    input  wire mem_if_pkg::mem_addr_t   rd_addr_i,
    input  wire                          rd_valid_i,
    output logic                         rd_grant_o,

    output mem_if_pkg::mem_port_t        mem_o,
    input  wire mem_if_pkg::axi_data_t   mem_q_i,
    output mem_if_pkg::axi_data_t        rd_q_o
);

    // Low favours the write side
    logic prio_rd_q;

    always_comb
    begin
        wr_grant_o = 1'b0;
        rd_grant_o = 1'b0;
        if (prio_rd_q)
        begin
            if (rd_valid_i)
                rd_grant_o = 1'b1;
            else if (wr_valid_i)
                wr_grant_o = 1'b1;
        end
        else
        begin
            if (wr_valid_i)
                wr_grant_o = 1'b1;
            else if (rd_valid_i)
                rd_grant_o = 1'b1;
        end
    end

    // --------------------
    // Port mux defaults to a read
    always_comb
    begin
        mem_o.cen  = ~(wr_grant_o | rd_grant_o);
        mem_o.wen  = ~wr_grant_o;
        mem_o.addr = wr_grant_o ? wr_req_i.addr : rd_addr_i;
        mem_o.data = wr_req_i.data;
        mem_o.be   = wr_grant_o ? wr_req_i.be : '1;
    end

    assign rd_q_o = mem_q_i;

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
            prio_rd_q <= 1'b0;
        else if (!mem_o.cen)
            prio_rd_q <= ~prio_rd_q;
    end

endmodule

`default_nettype wire

/* verification/axi_mem_if_tb.sv */
// --------------------
// Random burst testbench for the AXI to SRAM bridge
// Checks B and R traffic against a word array kept next to the SRAM model
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "mem_if_macros.svh"

module axi_mem_if_tb;

    localparam int MEM_WORDS       = 1 << `MEM_IF_MEM_ADDR_WIDTH;
    localparam int HALF            = MEM_WORDS / 2;
    localparam int BYTES           = `MEM_IF_DATA_WIDTH / 8;
    localparam int SEQ_BURSTS      = 16;
    localparam int CONC_BURSTS     = 24;
    localparam int MAX_BEATS       = 8;
    localparam int READBACK_BURSTS = MEM_WORDS / MAX_BEATS;
    localparam int CYCLES_PER_BEAT = 16;
    localparam int LIMIT_CYCLES    = (2 * SEQ_BURSTS + 2 * CONC_BURSTS + READBACK_BURSTS)
                                     * MAX_BEATS * CYCLES_PER_BEAT + 20;

    logic                    ACLK;
    logic                    ARESETn;
    mem_if_pkg::aw_chan_t    aw_i;
    logic                    aw_valid_i;
    logic                    aw_ready_o;
    mem_if_pkg::w_chan_t     w_i;
    logic                    w_valid_i;
    logic                    w_ready_o;
    mem_if_pkg::b_chan_t     b_o;
    logic                    b_valid_o;
    logic                    b_ready_i;
    mem_if_pkg::ar_chan_t    ar_i;
    logic                    ar_valid_i;
    logic                    ar_ready_o;
    mem_if_pkg::r_chan_t     r_o;
    logic                    r_valid_o;
    logic                    r_ready_i;
    mem_if_pkg::mem_port_t   mem_o;
    mem_if_pkg::axi_data_t   mem_q_i;

    // Reference memory and one LFSR per master process
    mem_if_pkg::axi_data_t   ref_mem [MEM_WORDS];
    logic [31:0]             wr_lfsr;
    logic [31:0]             rd_lfsr;

    axi_mem_if_sp dut
    (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw_i       (aw_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .w_i        (w_i),
        .w_valid_i  (w_valid_i),
        .w_ready_o  (w_ready_o),
        .b_o        (b_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .ar_i       (ar_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .r_o        (r_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .mem_o      (mem_o),
        .mem_q_i    (mem_q_i)
    );

    sp_sram_model u_sram
    (
        .ACLK  (ACLK),
        .mem_i (mem_o),
        .q_o   (mem_q_i)
    );

    always #50 ACLK = ~ACLK;

    // --------------------
    // Watchdog
    initial
    begin
        repeat (LIMIT_CYCLES) @(posedge ACLK);
        $display("timeout: bursts still running after %0d cycles", LIMIT_CYCLES);
        $display("Done: errors found");
        $fatal(1, "simulation stopped by watchdog");
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "stopping on first error");
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_bits(inout logic [31:0] state, input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            val   = {val[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 32'hB4BC_D35C) : (state >> 1);
        end
        return val;
    endfunction

    function automatic mem_if_pkg::axi_data_t fill_word(input mem_if_pkg::mem_addr_t a);
        return {6'h2B, a, 6'h15, ~a};
    endfunction

    function automatic void apply_write(input mem_if_pkg::mem_addr_t a,
                                        input mem_if_pkg::axi_data_t data,
                                        input mem_if_pkg::axi_strb_t strb);
        int b;
        for (b = 0; b < BYTES; b++)
        begin
            if (strb[b])
                ref_mem[a][8*b +: 8] = data[8*b +: 8];
        end
    endfunction

    // --------------------
    // Write master starts and ends on a falling edge
    task automatic write_burst(input mem_if_pkg::axi_id_t id, input mem_if_pkg::mem_addr_t start,
                               input mem_if_pkg::axi_len_t len);
        logic [31:0]           upper;
        logic [1:0]            mode;
        int                    final_beat;
        int                    beat;
        int                    gap;
        mem_if_pkg::axi_data_t data;
        mem_if_pkg::axi_strb_t strb;
        mem_if_pkg::b_chan_t   held;
        logic                  stalled;
        logic                  done;
        upper      = next_bits(wr_lfsr, 20);
        // Mode 0 may cut the burst short with WLAST
        // Mode 1 keeps WLAST low so the beat count ends the burst
        mode       = next_bits(wr_lfsr, 2);
        final_beat = len;
        if (mode == 2'd0)
            final_beat = next_bits(wr_lfsr, 3) % (len + 1);
        aw_i.id    = id;
        aw_i.addr  = {upper[19:0], start, 2'b00};
        aw_i.len   = len;
        aw_valid_i = 1'b1;
        do @(posedge ACLK); while (!aw_ready_o);
        @(negedge ACLK);
        aw_valid_i = 1'b0;
        for (beat = 0; beat <= final_beat; beat++)
        begin
            gap = next_bits(wr_lfsr, 2);
            repeat (gap) @(negedge ACLK);
            data      = next_bits(wr_lfsr, 32);
            strb      = next_bits(wr_lfsr, 4);
            w_i.data  = data;
            w_i.strb  = strb;
            w_i.last  = (beat == final_beat) && (mode != 2'd1);
            w_valid_i = 1'b1;
            do @(posedge ACLK); while (!w_ready_o);
            apply_write(mem_if_pkg::mem_addr_t'(start + beat), data, strb);
            @(negedge ACLK);
            w_valid_i = 1'b0;
        end
        stalled = 1'b0;
        done    = 1'b0;
        while (!done)
        begin
            b_ready_i = (next_bits(wr_lfsr, 2) != 2'b00);
            @(posedge ACLK);
            // B must hold while stalled
            if (stalled)
            begin
                check_value("b_valid_o", 1, b_valid_o);
                check_value("b_o", held, b_o);
            end
            stalled = b_valid_o && !b_ready_i;
            held    = b_o;
            if (b_valid_o && b_ready_i)
            begin
                check_value("b_o.id", id, b_o.id);
                check_value("b_o.resp", mem_if_pkg::RESP_OKAY, b_o.resp);
                done = 1'b1;
            end
            @(negedge ACLK);
        end
        b_ready_i = 1'b0;
        @(posedge ACLK);
        check_value("b_valid_o", 0, b_valid_o);
        @(negedge ACLK);
    endtask

    // --------------------
    // Read master
    task automatic read_burst(input mem_if_pkg::axi_id_t id, input mem_if_pkg::mem_addr_t start,
                              input mem_if_pkg::axi_len_t len);
        logic [31:0]           upper;
        int                    beat;
        mem_if_pkg::r_chan_t   held;
        logic                  stalled;
        upper      = next_bits(rd_lfsr, 20);
        ar_i.id    = id;
        ar_i.addr  = {upper[19:0], start, 2'b00};
        ar_i.len   = len;
        ar_valid_i = 1'b1;
        do @(posedge ACLK); while (!ar_ready_o);
        @(negedge ACLK);
        ar_valid_i = 1'b0;
        beat    = 0;
        stalled = 1'b0;
        while (beat <= len)
        begin
            r_ready_i = (next_bits(rd_lfsr, 2) != 2'b00);
            @(posedge ACLK);
            if (stalled)
            begin
                check_value("r_valid_o", 1, r_valid_o);
                check_value("r_o", held, r_o);
            end
            stalled = r_valid_o && !r_ready_i;
            held    = r_o;
            if (r_valid_o && r_ready_i)
            begin
                check_value("r_o.id", id, r_o.id);
                check_value("r_o.resp", mem_if_pkg::RESP_OKAY, r_o.resp);
                check_value("r_o.data", ref_mem[mem_if_pkg::mem_addr_t'(start + beat)], r_o.data);
                check_value("r_o.last", (beat == len), r_o.last);
                beat++;
            end
            @(negedge ACLK);
        end
        r_ready_i = 1'b0;
        // No extra beat after last
        @(posedge ACLK);
        check_value("r_valid_o", 0, r_valid_o);
        @(negedge ACLK);
    endtask

    // Concurrent phase writes in the lower half and reads in the upper half
    task automatic write_traffic();
        int                   k;
        int                   s;
        mem_if_pkg::axi_id_t  id;
        mem_if_pkg::axi_len_t len;
        for (k = 0; k < CONC_BURSTS; k++)
        begin
            id  = next_bits(wr_lfsr, 4);
            len = next_bits(wr_lfsr, 3);
            s   = next_bits(wr_lfsr, 9);
            if (s > HALF - MAX_BEATS)
                s = s - MAX_BEATS;
            write_burst(id, mem_if_pkg::mem_addr_t'(s), len);
        end
    endtask

    task automatic read_traffic();
        int                   k;
        int                   s;
        mem_if_pkg::axi_id_t  id;
        mem_if_pkg::axi_len_t len;
        for (k = 0; k < CONC_BURSTS; k++)
        begin
            id  = next_bits(rd_lfsr, 4);
            len = next_bits(rd_lfsr, 3);
            s   = next_bits(rd_lfsr, 9);
            if (s > HALF - MAX_BEATS)
                s = s - MAX_BEATS;
            read_burst(id, mem_if_pkg::mem_addr_t'(HALF + s), len);
        end
    endtask

    // --------------------
    // Main sequence
    initial
    begin
        int                    i;
        int                    k;
        mem_if_pkg::axi_id_t   id;
        mem_if_pkg::mem_addr_t start;
        mem_if_pkg::axi_len_t  len;
        ACLK       = 1'b0;
        ARESETn    = 1'b0;
        aw_i       = '0;
        aw_valid_i = 1'b0;
        w_i        = '0;
        w_valid_i  = 1'b0;
        b_ready_i  = 1'b0;
        ar_i       = '0;
        ar_valid_i = 1'b0;
        r_ready_i  = 1'b0;
        wr_lfsr    = 32'd92613;
        rd_lfsr    = next_bits(wr_lfsr, 32) | 32'h1;
        for (i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = fill_word(mem_if_pkg::mem_addr_t'(i));

        repeat (10) @(posedge ACLK);
        @(negedge ACLK);
        ARESETn = 1'b1;
        @(posedge ACLK);
        check_value("b_valid_o", 0, b_valid_o);
        check_value("r_valid_o", 0, r_valid_o);
        check_value("mem_o.cen", 1, mem_o.cen);
        check_value("aw_ready_o", 1, aw_ready_o);
        check_value("ar_ready_o", 1, ar_ready_o);
        @(negedge ACLK);

        // Write then read back the same words with wrap allowed
        for (k = 0; k < SEQ_BURSTS; k++)
        begin
            id    = next_bits(wr_lfsr, 4);
            start = next_bits(wr_lfsr, 10);
            len   = next_bits(wr_lfsr, 3);
            write_burst(id, start, len);
            read_burst(~id, start, len);
        end

        fork
            write_traffic();
            read_traffic();
        join

        for (k = 0; k < READBACK_BURSTS; k++)
            read_burst(mem_if_pkg::axi_id_t'(k), mem_if_pkg::mem_addr_t'(k * MAX_BEATS),
                       mem_if_pkg::axi_len_t'(MAX_BEATS - 1));

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/sp_sram_model.sv */
// --------------------
// Single-port synchronous SRAM with byte enables
// Sits on the bridge's SRAM port and returns read data one cycle after the access
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "mem_if_macros.svh"

module sp_sram_model
(
    input  wire                          ACLK,
    input  wire mem_if_pkg::mem_port_t   mem_i,
    output mem_if_pkg::axi_data_t        q_o
);

    localparam int DEPTH = 1 << `MEM_IF_MEM_ADDR_WIDTH;
    localparam int BYTES = `MEM_IF_DATA_WIDTH / 8;

    mem_if_pkg::axi_data_t mem [DEPTH];
    mem_if_pkg::axi_data_t q_q = '0;

    assign q_o = q_q;

    // Preload gives every word a pattern built from its own address
    initial
    begin : preload
        mem_if_pkg::mem_addr_t a;
        int                    i;
        for (i = 0; i < DEPTH; i++)
        begin
            a      = mem_if_pkg::mem_addr_t'(i);
            mem[i] = {6'h2B, a, 6'h15, ~a};
        end
    end

    always @(posedge ACLK)
    begin : access
        int b;
        if (!mem_i.cen)
        begin
            if (mem_i.wen)
                q_q <= mem[mem_i.addr];
            else
            begin
                for (b = 0; b < BYTES; b++)
                begin
                    if (mem_i.be[b])
                        mem[mem_i.addr][8*b +: 8] <= mem_i.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire
